// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mem_bridge
FILELIST   = all.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
source/bridge_pkg.sv
source/req_port.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/mem_bridge.sv
bench/axi_slave_model.sv
bench/tb_mem_bridge.sv

// File: bench/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model
    import bridge_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    // fresh random bits each cycle, stall pattern and delays
    input  wire logic [31:0] rnd,
    input  wire logic        arvalid,
    output logic             arready,
    input  wire addr_t       araddr,
    input  wire axi_id_t     arid,
    output axi_id_t          rid,
    output data_t            rdata,
    output logic             rvalid,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire addr_t       awaddr,
    input  wire axi_id_t     awid,
    input  wire logic        wvalid,
    output logic             wready,
    input  wire data_t       wdata,
    input  wire strb_t       wstrb,
    output axi_id_t          bid,
    output logic             bvalid
);

    localparam int MEM_BYTES = 1024;

    logic [7:0] mem [MEM_BYTES];
    // responses waiting for their cycle, oldest first
    int         r_due [$];
    axi_id_t    r_id [$];
    data_t      r_word [$];
    int         b_due [$];
    axi_id_t    b_id [$];
    // accepted write halves not yet paired
    addr_t      aw_q [$];
    axi_id_t    awid_q [$];
    data_t      w_q [$];
    strb_t      wstrb_q [$];
    int         cycle;
    int         r_last;
    int         b_last;

    function automatic data_t read_word(input addr_t a);
        data_t d;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            d[8*b +: 8] = mem[(int'(a % MEM_BYTES) + b) % MEM_BYTES];
        end
        return d;
    endfunction

    function automatic void write_word(input addr_t a, input data_t d, input strb_t s);
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (s[b]) begin
                mem[(int'(a % MEM_BYTES) + b) % MEM_BYTES] = d[8*b +: 8];
            end
        end
    endfunction

    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        rid     = '0;
        bid     = '0;
        rdata   = '0;
        cycle   = 0;
        r_last  = 0;
        b_last  = 0;
    end

    // everything moves on the falling edge, handshakes land on the next rising one
    always @(negedge clk) begin
        logic ar_rdy;
        logic aw_rdy;
        logic w_rdy;
        int   delay;
        // ready three cycles out of four
        ar_rdy = rnd[8] | rnd[9];
        aw_rdy = rnd[10] | rnd[11];
        w_rdy  = rnd[12] | rnd[13];
        delay  = 1 + int'(rnd[15:14]) % 3;
        if (!rst_n) begin
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            bvalid  = 1'b0;
        end else begin
            cycle++;
            if (arvalid && ar_rdy) begin
                // strictly increasing due cycles keep beats in order
                r_last = (cycle + delay > r_last) ? cycle + delay : r_last + 1;
                r_due.push_back(r_last);
                r_id.push_back(arid);
                r_word.push_back(read_word(araddr));
            end
            if (awvalid && aw_rdy) begin
                aw_q.push_back(awaddr);
                awid_q.push_back(awid);
            end
            if (wvalid && w_rdy) begin
                w_q.push_back(wdata);
                wstrb_q.push_back(wstrb);
            end
            // write lands once address and data are both in
            if (aw_q.size() > 0 && w_q.size() > 0) begin
                write_word(aw_q.pop_front(), w_q.pop_front(), wstrb_q.pop_front());
                b_last = (cycle + delay > b_last) ? cycle + delay : b_last + 1;
                b_due.push_back(b_last);
                b_id.push_back(awid_q.pop_front());
            end
            arready = ar_rdy;
            awready = aw_rdy;
            wready  = w_rdy;
            // single-cycle beats, the bridge never stalls R or B
            rvalid  = 1'b0;
            bvalid  = 1'b0;
            if (r_due.size() > 0 && r_due[0] <= cycle) begin
                void'(r_due.pop_front());
                rvalid = 1'b1;
                rid    = r_id.pop_front();
                rdata  = r_word.pop_front();
            end
            if (b_due.size() > 0 && b_due[0] <= cycle) begin
                void'(b_due.pop_front());
                bvalid = 1'b1;
                bid    = b_id.pop_front();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bridge
    import bridge_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int MEM_BYTES    = 1024;
    // directed requests first, then random ones on every port
    localparam int DIRECT_OPS   = 9;
    localparam int RAND_OPS     = 40;
    localparam int TOTAL_OPS    = DIRECT_OPS + NUM_PORTS * RAND_OPS;
    localparam int TIMEOUT      = RESET_CYCLES + 40 * TOTAL_OPS;

    logic                  clk;
    logic                  rst_n;
    logic [NUM_PORTS-1:0]  req_ce;
    logic [NUM_PORTS-1:0]  req_we;
    addr_t [NUM_PORTS-1:0] req_addr;
    data_t [NUM_PORTS-1:0] req_wdata;
    strb_t [NUM_PORTS-1:0] req_wmask;
    data_t [NUM_PORTS-1:0] resp_rdata;
    logic [NUM_PORTS-1:0]  resp_rdata_valid;
    logic [NUM_PORTS-1:0]  resp_write_finish;
    logic                  arvalid;
    logic                  arready;
    addr_t                 araddr;
    axi_id_t               arid;
    axi_id_t               rid;
    data_t                 rdata;
    logic                  rvalid;
    logic                  awvalid;
    logic                  awready;
    addr_t                 awaddr;
    axi_id_t               awid;
    logic                  wvalid;
    logic                  wready;
    data_t                 wdata;
    strb_t                 wstrb;
    axi_id_t               bid;
    logic                  bvalid;

    // reference memory and one expectation slot per port
    logic [7:0]            shadow [MEM_BYTES];
    logic [NUM_PORTS-1:0]  busy;
    logic                  pend_write [NUM_PORTS];
    addr_t                 exp_addr [NUM_PORTS];
    data_t                 exp_wdata [NUM_PORTS];
    strb_t                 exp_wmask [NUM_PORTS];
    data_t                 exp_rdata [NUM_PORTS];
    int                    issued [NUM_PORTS];
    int                    completed [NUM_PORTS];
    int                    errors;
    int                    cycles;
    logic [31:0]           port_rng [NUM_PORTS];
    logic [31:0]           stall_rng;
    // port served by the last address handshake on each engine
    axi_id_t               last_arid;
    axi_id_t               last_awid;
    logic                  ar_seen;
    logic                  aw_seen;

    mem_bridge DUT (.*);

    axi_slave_model u_slave (.rnd(stall_rng), .*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void count_error(input string msg);
        errors++;
        $display("%s", msg);
    endfunction

    function automatic data_t shadow_word(input addr_t a);
        data_t d;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            d[8*b +: 8] = shadow[(int'(a % MEM_BYTES) + b) % MEM_BYTES];
        end
        return d;
    endfunction

    function automatic void check_quiet();
        assert (!arvalid && !awvalid && !wvalid)
            else count_error($sformatf("bus valid raised around reset at %0t", $time));
        assert (resp_rdata_valid == '0 && resp_write_finish == '0)
            else count_error($sformatf("completion pulse around reset at %0t", $time));
    endfunction

    function automatic void check_completion(input int p);
        assert (busy[p])
            else count_error($sformatf("port %0d completed with nothing outstanding", p));
        assert (!(resp_rdata_valid[p] && resp_write_finish[p]))
            else count_error($sformatf("port %0d gave read and write completion", p));
        assert (resp_write_finish[p] == pend_write[p])
            else count_error($sformatf("port %0d completion of the wrong kind", p));
        if (resp_rdata_valid[p]) begin
            assert (resp_rdata[p] === exp_rdata[p])
                else count_error($sformatf("error %0t resp_rdata[%0d] got %h expected %h",
                                           $time, p, resp_rdata[p], exp_rdata[p]));
        end
        busy[p] = 1'b0;
        completed[p]++;
    endfunction

    // one request on port p, once its previous one has finished
    task automatic issue(input int p, input logic we, input addr_t a,
                         input data_t d, input strb_t m);
        @(posedge clk);
        while (busy[p]) begin
            @(posedge clk);
        end
        @(negedge clk);
        exp_addr[p]   = a;
        exp_wdata[p]  = d;
        exp_wmask[p]  = m;
        pend_write[p] = we;
        if (we) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (m[b]) begin
                    shadow[(int'(a % MEM_BYTES) + b) % MEM_BYTES] = d[8*b +: 8];
                end
            end
        end else begin
            exp_rdata[p] = shadow_word(a);
        end
        busy[p] = 1'b1;
        issued[p]++;
        req_ce[p]    = 1'b1;
        req_we[p]    = we;
        req_addr[p]  = a;
        req_wdata[p] = d;
        req_wmask[p] = m;
        @(negedge clk);
        req_ce[p] = 1'b0;
    endtask

    // every port back to idle, so forked requests start on the same edge
    task automatic wait_all_idle();
        @(posedge clk);
        while (busy != '0) begin
            @(posedge clk);
        end
    endtask

    task automatic run_random(input int p);
        logic [31:0] r;
        logic [31:0] d;
        addr_t       a;
        for (int i = 0; i < RAND_OPS; i++) begin
            r = lcg_next(port_rng[p]);
            d = lcg_next(r);
            port_rng[p] = d;
            // 16 words per port, each port in its own half of memory
            a = addr_t'(p * (MEM_BYTES / 2) + 4 * int'(r[19:16]));
            issue(p, r[28], a, d, r[23:20]);
        end
    endtask

    // completions sampled mid-cycle, where they are stable
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (resp_rdata_valid[p] || resp_write_finish[p]) begin
                    check_completion(p);
                end
            end
        end
    end

    always @(posedge clk) begin
        stall_rng <= lcg_next(stall_rng);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_seen   <= 1'b0;
            aw_seen   <= 1'b0;
            last_arid <= '0;
            last_awid <= '0;
        end else begin
            if (arvalid && arready) begin
                ar_seen   <= 1'b1;
                last_arid <= arid;
            end
            if (awvalid && awready) begin
                aw_seen   <= 1'b1;
                last_awid <= awid;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, a completion never arrived", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus payload matches the request of the port named by the id
    a_araddr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> araddr == exp_addr[arid])
        else count_error($sformatf("error %0t araddr got %h expected %h",
                                   $time, araddr, exp_addr[arid]));
    a_awaddr: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> awaddr == exp_addr[awid])
        else count_error($sformatf("error %0t awaddr got %h expected %h",
                                   $time, awaddr, exp_addr[awid]));
    a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wdata == exp_wdata[awid])
        else count_error($sformatf("error %0t wdata got %h expected %h",
                                   $time, wdata, exp_wdata[awid]));
    a_wstrb: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wstrb == exp_wmask[awid])
        else count_error($sformatf("error %0t wstrb got %h expected %h",
                                   $time, wstrb, exp_wmask[awid]));

    // back-pressure holds every channel steady
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
        else count_error("AR channel changed while arready was low");
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
        else count_error("AW channel changed while awready was low");
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else count_error("W channel changed while wready was low");

    // both ports waiting at an idle engine, the pick skips the port served last
    a_ar_fair: assert property (@(posedge clk) disable iff (!rst_n)
        ar_seen && !arvalid && (&DUT.rd_req) |=> arvalid && arid != last_arid)
        else count_error("read arbitration did not alternate between waiting ports");
    a_aw_fair: assert property (@(posedge clk) disable iff (!rst_n)
        aw_seen && !awvalid && !wvalid && (&DUT.wr_req) |=> awvalid && awid != last_awid)
        else count_error("write arbitration did not alternate between waiting ports");

    initial begin
        logic [31:0] seed;
        int          total_issued;
        int          total_done;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_ce    = '0;
        req_we    = '0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        busy      = '0;
        errors    = 0;
        cycles    = 0;
        seed      = 32'd97;
        for (int p = 0; p < NUM_PORTS; p++) begin
            seed          = lcg_next(seed);
            port_rng[p]   = seed;
            pend_write[p] = 1'b0;
            exp_addr[p]   = '0;
            exp_wdata[p]  = '0;
            exp_wmask[p]  = '0;
            exp_rdata[p]  = '0;
            issued[p]     = 0;
            completed[p]  = 0;
        end
        stall_rng = lcg_next(seed);
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_quiet();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet();

        // partial mask merges into the old word
        issue(1, 1'b1, 32'h240, 32'h11223344, 4'hf);
        issue(1, 1'b1, 32'h240, 32'haabbccdd, 4'b0101);
        issue(1, 1'b0, 32'h240, '0, '0);
        wait_all_idle();
        // full word write, then read back on port 0
        // port 0 served last, so round robin must favour port 1 next
        issue(0, 1'b1, 32'h40, 32'hdeadbeef, 4'hf);
        issue(0, 1'b0, 32'h40, '0, '0);
        // both ports on one engine at once
        wait_all_idle();
        fork
            issue(0, 1'b0, 32'h40, '0, '0);
            issue(1, 1'b0, 32'h240, '0, '0);
        join
        wait_all_idle();
        fork
            issue(0, 1'b1, 32'h44, 32'h01020304, 4'b1100);
            issue(1, 1'b1, 32'h244, 32'h05060708, 4'b0011);
        join
        fork
            run_random(0);
            run_random(1);
        join

        // drain the last responses
        wait_all_idle();
        @(negedge clk);
        total_issued = 0;
        total_done   = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (issued[p] == completed[p])
                else count_error($sformatf("port %0d lost a completion", p));
            total_issued += issued[p];
            total_done   += completed[p];
        end
        $display("checks finished with %0d errors over %0d requests, %0d completed",
                 errors, total_issued, total_done);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine
    import bridge_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // port side
    input  wire logic [NUM_PORTS-1:0]  rd_req,
    input  wire addr_t [NUM_PORTS-1:0] req_addr,
    output logic [NUM_PORTS-1:0]       rd_grant,
    output logic [NUM_PORTS-1:0]       rd_done,
    output data_t                      rd_data,
    // AR channel
    output logic                       arvalid,
    input  wire logic                  arready,
    output addr_t                      araddr,
    output axi_id_t                    arid,
    // R channel, always accepted
    input  wire axi_id_t               rid,
    input  wire data_t                 rdata,
    input  wire logic                  rvalid
);

    eng_state_t state;
    // first port to look at next time
    axi_id_t    rr_ptr;
    axi_id_t    pick_id;
    logic       pick_found;

    // round robin search starting at the pointer
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_id    = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!pick_found && rd_req[cand]) begin
                pick_found = 1'b1;
                pick_id    = axi_id_t'(cand);
            end
        end
    end

    assign arvalid = (state == eng_issue);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= eng_idle;
            rr_ptr <= '0;
        end else begin
            case (state)
                eng_idle: begin
                    if (pick_found) begin
                        state <= eng_issue;
                    end
                end
                eng_issue: begin
                    // pointer moves past the port just served
                    if (arready) begin
                        state  <= eng_idle;
                        rr_ptr <= axi_id_t'((int'(arid) + 1) % NUM_PORTS);
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // address and id frozen for the whole issue phase
    always_ff @(posedge clk) begin
        if (state == eng_idle && pick_found) begin
            araddr <= req_addr[pick_id];
            arid   <= pick_id;
        end
    end

    // grant on the handshake, done decoded from rid
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            rd_grant[i] = arvalid && arready && (arid == axi_id_t'(i));
            rd_done[i]  = rvalid && (rid == axi_id_t'(i));
        end
    end

    // data shared, the done pulse selects the receiver
    assign rd_data = rdata;

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));

endmodule

`default_nettype wire

// File: source/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine
    import bridge_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // port side
    input  wire logic [NUM_PORTS-1:0]  wr_req,
    input  wire addr_t [NUM_PORTS-1:0] req_addr,
    input  wire data_t [NUM_PORTS-1:0] req_wdata,
    input  wire strb_t [NUM_PORTS-1:0] req_wmask,
    output logic [NUM_PORTS-1:0]       wr_grant,
    output logic [NUM_PORTS-1:0]       wr_done,
    // AW channel
    output logic                       awvalid,
    input  wire logic                  awready,
    output addr_t                      awaddr,
    output axi_id_t                    awid,
    // W channel
    output logic                       wvalid,
    input  wire logic                  wready,
    output data_t                      wdata,
    output strb_t                      wstrb,
    // B channel, always accepted
    input  wire axi_id_t               bid,
    input  wire logic                  bvalid
);

    eng_state_t state;
    axi_id_t    rr_ptr;
    axi_id_t    pick_id;
    logic       pick_found;
    // handshakes already taken in this issue phase
    logic       aw_acc;
    logic       w_acc;
    logic       both_done;

    // round robin search starting at the pointer
    always_comb begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_id    = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!pick_found && wr_req[cand]) begin
                pick_found = 1'b1;
                pick_id    = axi_id_t'(cand);
            end
        end
    end

    // each valid drops after its own handshake
    assign awvalid = (state == eng_issue) && !aw_acc;
    assign wvalid  = (state == eng_issue) && !w_acc;

    // AW and W may finish in either order or together
    assign both_done = (state == eng_issue)
                       && (aw_acc || awready)
                       && (w_acc || wready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= eng_idle;
            rr_ptr <= '0;
            aw_acc <= 1'b0;
            w_acc  <= 1'b0;
        end else begin
            case (state)
                eng_idle: begin
                    if (pick_found) begin
                        state <= eng_issue;
                    end
                end
                eng_issue: begin
                    if (both_done) begin
                        state  <= eng_idle;
                        aw_acc <= 1'b0;
                        w_acc  <= 1'b0;
                        rr_ptr <= axi_id_t'((int'(awid) + 1) % NUM_PORTS);
                    end else begin
                        if (awvalid && awready) begin
                            aw_acc <= 1'b1;
                        end
                        if (wvalid && wready) begin
                            w_acc <= 1'b1;
                        end
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // payload of the chosen port, mask goes out as wstrb
    always_ff @(posedge clk) begin
        if (state == eng_idle && pick_found) begin
            awaddr <= req_addr[pick_id];
            awid   <= pick_id;
            wdata  <= req_wdata[pick_id];
            wstrb  <= req_wmask[pick_id];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            wr_grant[i] = both_done && (awid == axi_id_t'(i));
            wr_done[i]  = bvalid && (bid == axi_id_t'(i));
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

`default_nettype wire

// File: source/bridge_pkg.sv
`default_nettype none

// shared widths and types for the two-port AXI memory bridge
package bridge_pkg;

    // requester ports sharing the bus
    localparam int NUM_PORTS  = 2;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    // one strobe bit per data byte
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    // id carries the port index, never narrower than one bit
    localparam int ID_WIDTH   = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0]   axi_id_t;

    // requester slot FSM
    typedef enum logic [1:0] {
        port_idle,
        port_wait_grant,
        port_wait_resp
    } port_state_t;

    // address phase of either engine
    typedef enum logic {
        eng_idle,
        eng_issue
    } eng_state_t;

endpackage

`default_nettype wire

// File: source/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge
    import bridge_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // requester ports
    input  wire logic [NUM_PORTS-1:0]  req_ce,
    input  wire logic [NUM_PORTS-1:0]  req_we,
    input  wire addr_t [NUM_PORTS-1:0] req_addr,
    input  wire data_t [NUM_PORTS-1:0] req_wdata,
    input  wire strb_t [NUM_PORTS-1:0] req_wmask,
    output data_t [NUM_PORTS-1:0]      resp_rdata,
    output logic [NUM_PORTS-1:0]       resp_rdata_valid,
    output logic [NUM_PORTS-1:0]       resp_write_finish,
    // AXI read
    output logic                       arvalid,
    input  wire logic                  arready,
    output addr_t                      araddr,
    output axi_id_t                    arid,
    input  wire axi_id_t               rid,
    input  wire data_t                 rdata,
    input  wire logic                  rvalid,
    // AXI write
    output logic                       awvalid,
    input  wire logic                  awready,
    output addr_t                      awaddr,
    output axi_id_t                    awid,
    output logic                       wvalid,
    input  wire logic                  wready,
    output data_t                      wdata,
    output strb_t                      wstrb,
    input  wire axi_id_t               bid,
    input  wire logic                  bvalid
);

    // per-slot requests towards the engines
    logic [NUM_PORTS-1:0]  rd_req;
    logic [NUM_PORTS-1:0]  wr_req;
    addr_t [NUM_PORTS-1:0] slot_addr;
    data_t [NUM_PORTS-1:0] slot_wdata;
    strb_t [NUM_PORTS-1:0] slot_wmask;
    // engine answers
    logic [NUM_PORTS-1:0]  rd_grant;
    logic [NUM_PORTS-1:0]  rd_done;
    logic [NUM_PORTS-1:0]  wr_grant;
    logic [NUM_PORTS-1:0]  wr_done;
    data_t                 rd_data;

    // one slot per requester, index doubles as AXI id
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        req_port u_port (
            .clk          (clk),
            .rst_n        (rst_n),
            .ce           (req_ce[i]),
            .we           (req_we[i]),
            .addr         (req_addr[i]),
            .wdata        (req_wdata[i]),
            .wmask        (req_wmask[i]),
            .rdata        (resp_rdata[i]),
            .rdata_valid  (resp_rdata_valid[i]),
            .write_finish (resp_write_finish[i]),
            .rd_req       (rd_req[i]),
            .wr_req       (wr_req[i]),
            .req_addr     (slot_addr[i]),
            .req_wdata    (slot_wdata[i]),
            .req_wmask    (slot_wmask[i]),
            .rd_grant     (rd_grant[i]),
            .rd_done      (rd_done[i]),
            .rd_data      (rd_data),
            .wr_grant     (wr_grant[i]),
            .wr_done      (wr_done[i])
        );
    end

    axi_read_engine u_rd_eng (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_req   (rd_req),
        .req_addr (slot_addr),
        .rd_grant (rd_grant),
        .rd_done  (rd_done),
        .rd_data  (rd_data),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .arid     (arid),
        .rid      (rid),
        .rdata    (rdata),
        .rvalid   (rvalid)
    );

    axi_write_engine u_wr_eng (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .req_addr  (slot_addr),
        .req_wdata (slot_wdata),
        .req_wmask (slot_wmask),
        .wr_grant  (wr_grant),
        .wr_done   (wr_done),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awid      (awid),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bid       (bid),
        .bvalid    (bvalid)
    );

endmodule

`default_nettype wire

// File: source/req_port.sv
`timescale 1ns/1ps
`default_nettype none

module req_port
    import bridge_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    // requester side
    input  wire logic  ce,
    input  wire logic  we,
    input  wire addr_t addr,
    input  wire data_t wdata,
    input  wire strb_t wmask,
    output data_t      rdata,
    output logic       rdata_valid,
    output logic       write_finish,
    // engine side
    output logic       rd_req,
    output logic       wr_req,
    output addr_t      req_addr,
    output data_t      req_wdata,
    output strb_t      req_wmask,
    input  wire logic  rd_grant,
    input  wire logic  rd_done,
    input  wire data_t rd_data,
    input  wire logic  wr_grant,
    input  wire logic  wr_done
);

    port_state_t state;
    // latched direction, high for a write
    logic        is_write;

    // request visible to an engine only while waiting for grant
    assign rd_req = (state == port_wait_grant) && !is_write;
    assign wr_req = (state == port_wait_grant) && is_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= port_idle;
            is_write     <= 1'b0;
            rdata_valid  <= 1'b0;
            write_finish <= 1'b0;
        end else begin
            // completion strobes last one cycle
            rdata_valid  <= 1'b0;
            write_finish <= 1'b0;
            case (state)
                port_idle: begin
                    if (ce) begin
                        is_write <= we;
                        state    <= port_wait_grant;
                    end
                end
                port_wait_grant: begin
                    // address accepted on the bus
                    if (is_write ? wr_grant : rd_grant) begin
                        state <= port_wait_resp;
                    end
                end
                port_wait_resp: begin
                    if (is_write && wr_done) begin
                        write_finish <= 1'b1;
                        state        <= port_idle;
                    end else if (!is_write && rd_done) begin
                        rdata_valid <= 1'b1;
                        state       <= port_idle;
                    end
                end
                default: state <= port_idle;
            endcase
        end
    end

    // request payload, held until the engine takes it
    always_ff @(posedge clk) begin
        if (ce && state == port_idle) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wmask <= wmask;
        end
    end

    // read word captured with the R beat
    always_ff @(posedge clk) begin
        if (rd_done && state == port_wait_resp && !is_write) begin
            rdata <= rd_data;
        end
    end

    // requester must wait for the previous completion
    a_ce_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        ce |-> state == port_idle);

    // responses only for an outstanding request of the same kind
    a_done_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_done || wr_done) |-> state == port_wait_resp && (wr_done == is_write));

endmodule

`default_nettype wire
